// File: all.f
src/bk_pkg.sv
src/bk_regfile.sv
src/bk_issue.sv
src/bk_alu_unit.sv
src/bk_mem_unit.sv
src/bk_commit.sv
src/bk_top.sv
verif/bk_tb_mem.sv
verif/bk_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --top-module bk_tb -f all.f -o bk_sim \
  && ./obj_dir/bk_sim 2>&1 | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "No pass line in log"; exit 1; }
exit 0

// File: verif/bk_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bk_tb;
  import bk_pkg::*;

  localparam int SEED    = 24;
  localparam int TIMEOUT = 200;

  typedef struct {
    bit        is_trap;
    reg_addr_t rd;
    word_t     data;
    word_t     next_pc;
    cause_t    cause;
  } commit_t;

  logic             clk_core;
  logic             rst_core_n;
  logic             insn_valid;
  logic             insn_ready;
  op_t              insn_op;
  reg_addr_t        insn_rd, insn_rs1, insn_rs2;
  word_t            insn_imm, insn_pc;
  logic             wb_cyc, wb_stb, wb_we, wb_ack;
  word_t            wb_adr, wb_dat_w, wb_dat_r;
  logic [SEL_W-1:0] wb_sel;
  logic             wb_en;
  reg_addr_t        wb_addr;
  word_t            wb_data;
  logic             trap;
  cause_t           trap_cause;
  word_t            trap_value, next_pc;

  commit_t   exp_q[$];
  word_t     ref_regs [REG_N];
  word_t     ref_mem [logic [7:0]];
  word_t     pc;
  logic      pc_pending;
  word_t     pc_expected;
  int        errors;
  int        checks;

  bk_top dut0 (
    .clk_core, .rst_core_n, .insn_valid_i(insn_valid), .insn_ready_o(insn_ready),
    .insn_op_i(insn_op), .insn_rd_i(insn_rd), .insn_rs1_i(insn_rs1),
    .insn_rs2_i(insn_rs2), .insn_imm_i(insn_imm), .insn_pc_i(insn_pc),
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel), .wb_ack_i(wb_ack), .wb_dat_i(wb_dat_r),
    .wb_en_o(wb_en), .wb_addr_o(wb_addr), .wb_data_o(wb_data), .trap_o(trap),
    .trap_cause_o(trap_cause), .trap_value_o(trap_value), .next_pc_o(next_pc)
  );

  bk_tb_mem #(.SEED(SEED)) mem0 (
    .clk_core, .rst_core_n, .cyc_i(wb_cyc), .stb_i(wb_stb), .we_i(wb_we),
    .adr_i(wb_adr), .dat_i(wb_dat_w), .sel_i(wb_sel), .ack_o(wb_ack), .dat_o(wb_dat_r)
  );

  always #2 clk_core = ~clk_core;

  function automatic word_t fill_word(logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5a, idx + 8'h11};
  endfunction

  // Outputs are settled by the falling edge
  always @(negedge clk_core) begin
    commit_t head;
    if (rst_core_n) begin
      if (pc_pending) begin
        checks++;
        assert (next_pc == pc_expected) else begin
          $display("[ERROR] %0t: next_pc %h, expected %h", $time, next_pc, pc_expected);
          errors++;
        end
        pc_pending = 1'b0;
      end
      if (wb_en || trap) begin
        checks++;
        if (exp_q.size() == 0) begin
          $display("[ERROR] %0t: commit event with nothing expected", $time);
          errors++;
        end else begin
          head = exp_q.pop_front();
          if (wb_en) begin
            assert (!head.is_trap && wb_addr == head.rd && wb_data == head.data) else begin
              $display("[ERROR] %0t: writeback r%0d=%h, expected trap=%0b r%0d=%h",
                       $time, wb_addr, wb_data, head.is_trap, head.rd, head.data);
              errors++;
            end
            pc_pending  = 1'b1;
            pc_expected = head.next_pc;
          end else begin
            assert (head.is_trap && trap_cause == head.cause && trap_value == head.data)
            else begin
              $display("[ERROR] %0t: trap cause %0d value %h, expected %0d %h",
                       $time, trap_cause, trap_value, head.cause, head.data);
              errors++;
            end
          end
        end
      end
    end
  end

  // Computes the expected outcome in program order, then offers the op
  task automatic send(op_t op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                      word_t imm, bit commits);
    commit_t e;
    word_t   a;
    word_t   b;
    bit      accepted;
    int      n;
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    e.is_trap = 1'b0;
    e.rd      = rd;
    e.next_pc = pc + 32'd1;
    e.cause   = '0;
    case (op)
      OP_ADD:  e.data = a + b;
      OP_SUB:  e.data = a - b;
      OP_XOR:  e.data = a ^ b;
      OP_ADDI: e.data = a + imm;
      default: begin
        e.data = a + imm;
        if (e.data[1:0] != 2'b00) begin
          e.is_trap = 1'b1;
          e.cause   = (op == OP_STORE) ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
        end else if (op == OP_STORE) begin
          if (commits) ref_mem[e.data[9:2]] = b;
        end else if (ref_mem.exists(e.data[9:2])) begin
          e.data = ref_mem[e.data[9:2]];
        end else begin
          e.data = fill_word(e.data[9:2]);
        end
      end
    endcase
    if (commits && (op != OP_STORE || e.is_trap)) begin
      exp_q.push_back(e);
      if (!e.is_trap && rd != '0) ref_regs[rd] = e.data;
    end
    insn_valid = 1'b1;
    insn_op    = op;
    insn_rd    = rd;
    insn_rs1   = rs1;
    insn_rs2   = rs2;
    insn_imm   = imm;
    insn_pc    = pc;
    accepted   = 1'b0;
    n          = 0;
    while (!accepted && n < TIMEOUT) begin
      @(negedge clk_core);
      accepted = insn_ready;
      @(posedge clk_core);
      #1;
      n++;
    end
    if (!accepted) begin
      $display("Timed out waiting for the DUT to accept the op at pc %h", pc);
      errors++;
    end
    insn_valid = 1'b0;
    pc = pc + 32'd1;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < TIMEOUT) begin
      @(posedge clk_core);
      #1;
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out with %0d expected commits still outstanding", exp_q.size());
      errors++;
    end
  endtask

  task automatic wait_trap_vector();
    int n;
    n = 0;
    while (next_pc != TRAP_VECTOR && n < TIMEOUT) begin
      @(posedge clk_core);
      #1;
      n++;
    end
    checks++;
    if (next_pc != TRAP_VECTOR) begin
      $display("Timed out waiting for the next PC to reach the trap vector");
      errors++;
    end
  endtask

  initial begin
    clk_core   = 1'b0;
    rst_core_n = 1'b0;
    insn_valid = 1'b0;
    insn_op    = OP_ADD;
    insn_rd    = '0;
    insn_rs1   = '0;
    insn_rs2   = '0;
    insn_imm   = '0;
    insn_pc    = '0;
    pc         = 32'h0000_0040;
    pc_pending = 1'b0;
    errors     = 0;
    checks     = 0;
    for (int i = 0; i < REG_N; i++) begin
      ref_regs[i] = '0;
    end
    repeat (16) @(posedge clk_core);
    #1;
    checks++;
    assert (!insn_ready && !wb_cyc && !wb_en && !trap && next_pc == '0) else begin
      $display("[ERROR] %0t: outputs not idle after reset", $time);
      errors++;
    end
    rst_core_n = 1'b1;

    // Plain ALU chain
    send(OP_ADDI, 4'd1, 4'd0, 4'd0, 32'd5, 1'b1);
    send(OP_ADDI, 4'd2, 4'd0, 4'd0, 32'h30, 1'b1);
    send(OP_ADD, 4'd3, 4'd1, 4'd2, '0, 1'b1);
    send(OP_SUB, 4'd4, 4'd3, 4'd1, '0, 1'b1);
    send(OP_XOR, 4'd5, 4'd4, 4'd2, '0, 1'b1);
    send(OP_ADDI, 4'd1, 4'd1, 4'd0, -32'sd3, 1'b1);
    // Load overtaken by a faster ALU op
    send(OP_LOAD, 4'd6, 4'd2, 4'd0, 32'h10, 1'b1);
    send(OP_ADDI, 4'd7, 4'd0, 4'd0, 32'd9, 1'b1);
    // Use right after load
    send(OP_LOAD, 4'd8, 4'd2, 4'd0, 32'd4, 1'b1);
    send(OP_ADD, 4'd9, 4'd8, 4'd1, '0, 1'b1);
    // Store then reload
    send(OP_STORE, 4'd0, 4'd2, 4'd5, 32'd8, 1'b1);
    send(OP_LOAD, 4'd10, 4'd2, 4'd0, 32'd8, 1'b1);
    drain();

    // Misaligned accesses, each followed by an op that gets squashed
    send(OP_LOAD, 4'd11, 4'd2, 4'd0, 32'd2, 1'b1);
    send(OP_ADDI, 4'd12, 4'd0, 4'd0, 32'd1, 1'b0);
    drain();
    wait_trap_vector();
    // Moves the next PC off the trap vector again
    send(OP_ADDI, 4'd11, 4'd1, 4'd0, 32'd3, 1'b1);
    drain();
    send(OP_STORE, 4'd0, 4'd2, 4'd5, 32'd1, 1'b1);
    send(OP_ADDI, 4'd13, 4'd0, 4'd0, 32'd2, 1'b0);
    drain();
    wait_trap_vector();

    // Fresh sequence from token zero
    send(OP_ADDI, 4'd12, 4'd0, 4'd0, 32'd7, 1'b1);
    send(OP_ADD, 4'd13, 4'd12, 4'd9, '0, 1'b1);
    send(OP_LOAD, 4'd14, 4'd2, 4'd0, 32'h10, 1'b1);
    send(OP_XOR, 4'd15, 4'd14, 4'd13, '0, 1'b1);
    drain();
    repeat (20) @(posedge clk_core);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/bk_tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module bk_tb_mem #(
  parameter int SEED = 1
) (
  input  wire         clk_core,
  input  wire         rst_core_n,
  input  wire         cyc_i,
  input  wire         stb_i,
  input  wire         we_i,
  input  wire  [31:0] adr_i,
  input  wire  [31:0] dat_i,
  input  wire  [3:0]  sel_i,
  output logic        ack_o,
  output logic [31:0] dat_o
);

  logic [31:0] mem [256];
  int          seed;
  int          wait_cnt;

  // Known contents, every byte tied to the word index
  function automatic logic [31:0] fill_word(logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5a, idx + 8'h11};
  endfunction

  initial begin
    seed     = SEED;
    ack_o    = 1'b0;
    dat_o    = '0;
    wait_cnt = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = fill_word(8'(i));
    end
  end

  // Classic slave, 0 to 3 wait states per access
  always begin
    @(posedge clk_core);
    #1;
    if (!rst_core_n || ack_o) begin
      ack_o    = 1'b0;
      wait_cnt = $unsigned($random(seed)) % 4;
    end else if (cyc_i && stb_i) begin
      if (wait_cnt == 0) begin
        if (we_i) begin
          // Byte lanes follow sel
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) mem[adr_i[9:2]][8*b +: 8] = dat_i[8*b +: 8];
          end
        end
        dat_o = mem[adr_i[9:2]];
        ack_o = 1'b1;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/bk_top.sv
`timescale 1ns/1ps
`default_nettype none

module bk_top
  import bk_pkg::*;
(
  input  logic             clk_core,
  input  logic             rst_core_n,
  input  logic             insn_valid_i,
  output logic             insn_ready_o,
  input  op_t              insn_op_i,
  input  reg_addr_t        insn_rd_i,
  input  reg_addr_t        insn_rs1_i,
  input  reg_addr_t        insn_rs2_i,
  input  word_t            insn_imm_i,
  input  word_t            insn_pc_i,
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output logic             wb_we_o,
  output word_t            wb_adr_o,
  output word_t            wb_dat_o,
  output logic [SEL_W-1:0] wb_sel_o,
  input  logic             wb_ack_i,
  input  word_t            wb_dat_i,
  output logic             wb_en_o,
  output reg_addr_t        wb_addr_o,
  output word_t            wb_data_o,
  output logic             trap_o,
  output cause_t           trap_cause_o,
  output word_t            trap_value_o,
  output word_t            next_pc_o
);

  reg_addr_t rf_addr_a, rf_addr_b;
  word_t     rf_data_a, rf_data_b;
  logic      alu_issue_valid, mem_issue_valid, alu_free, mem_free;
  token_t    iss_token;
  op_t       iss_op;
  reg_addr_t iss_rd;
  word_t     iss_a, iss_b, iss_imm, iss_pc;
  logic      alu_valid, alu_wb, alu_ready;
  token_t    alu_token;
  reg_addr_t alu_rd;
  word_t     alu_result, alu_next_pc;
  logic      mem_valid, mem_wb, mem_trap, mem_ready;
  token_t    mem_token;
  reg_addr_t mem_rd;
  word_t     mem_result, mem_next_pc, mem_tval;
  cause_t    mem_cause;
  reg_mask_t commit_mask;
  logic      retire, flush_begin, flush_req, flush_ack;

  bk_issue issue0 (
    .clk_core, .rst_core_n, .insn_valid_i, .insn_ready_o, .insn_op_i, .insn_rd_i,
    .insn_rs1_i, .insn_rs2_i, .insn_imm_i, .insn_pc_i,
    .rf_addr_a_o(rf_addr_a), .rf_addr_b_o(rf_addr_b),
    .rf_data_a_i(rf_data_a), .rf_data_b_i(rf_data_b),
    .alu_valid_o(alu_issue_valid), .mem_valid_o(mem_issue_valid),
    .iss_token_o(iss_token), .iss_op_o(iss_op), .iss_rd_o(iss_rd), .iss_a_o(iss_a),
    .iss_b_o(iss_b), .iss_imm_o(iss_imm), .iss_pc_o(iss_pc),
    .alu_free_i(alu_free), .mem_free_i(mem_free), .commit_mask_i(commit_mask),
    .retire_i(retire), .flush_begin_i(flush_begin), .flush_req_o(flush_req),
    .flush_ack_i(flush_ack)
  );

  bk_regfile regfile0 (
    .clk_core, .rst_core_n, .rd_addr_a_i(rf_addr_a), .rd_addr_b_i(rf_addr_b),
    .rd_data_a_o(rf_data_a), .rd_data_b_o(rf_data_b),
    .wr_en_i(wb_en_o), .wr_addr_i(wb_addr_o), .wr_data_i(wb_data_o)
  );

  bk_alu_unit alu0 (
    .clk_core, .rst_core_n, .valid_i(alu_issue_valid), .free_o(alu_free),
    .token_i(iss_token), .op_i(iss_op), .rd_i(iss_rd), .a_i(iss_a), .b_i(iss_b),
    .imm_i(iss_imm), .pc_i(iss_pc), .flush_i(flush_begin),
    .valid_o(alu_valid), .token_o(alu_token), .rd_o(alu_rd), .wb_o(alu_wb),
    .result_o(alu_result), .next_pc_o(alu_next_pc), .ready_i(alu_ready)
  );

  bk_mem_unit mem0 (
    .clk_core, .rst_core_n, .valid_i(mem_issue_valid), .free_o(mem_free),
    .token_i(iss_token), .op_i(iss_op), .rd_i(iss_rd), .a_i(iss_a), .b_i(iss_b),
    .imm_i(iss_imm), .pc_i(iss_pc), .flush_i(flush_begin),
    .valid_o(mem_valid), .token_o(mem_token), .rd_o(mem_rd), .wb_o(mem_wb),
    .result_o(mem_result), .next_pc_o(mem_next_pc), .trap_o(mem_trap),
    .cause_o(mem_cause), .tval_o(mem_tval), .ready_i(mem_ready),
    .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o, .wb_sel_o, .wb_ack_i, .wb_dat_i
  );

  bk_commit commit0 (
    .clk_core, .rst_core_n,
    .alu_valid_i(alu_valid), .alu_token_i(alu_token), .alu_rd_i(alu_rd),
    .alu_wb_i(alu_wb), .alu_result_i(alu_result), .alu_next_pc_i(alu_next_pc),
    .alu_ready_o(alu_ready),
    .mem_valid_i(mem_valid), .mem_token_i(mem_token), .mem_rd_i(mem_rd),
    .mem_wb_i(mem_wb), .mem_result_i(mem_result), .mem_next_pc_i(mem_next_pc),
    .mem_trap_i(mem_trap), .mem_cause_i(mem_cause), .mem_tval_i(mem_tval),
    .mem_ready_o(mem_ready),
    .flush_req_i(flush_req), .flush_ack_o(flush_ack), .flush_begin_o(flush_begin),
    .retire_o(retire), .wr_en_o(wb_en_o), .wr_addr_o(wb_addr_o), .wr_data_o(wb_data_o),
    .commit_mask_o(commit_mask), .trap_o, .trap_cause_o, .trap_value_o, .next_pc_o
  );

endmodule

`default_nettype wire

// File: src/bk_commit.sv
`timescale 1ns/1ps
`default_nettype none

module bk_commit
  import bk_pkg::*;
(
  input  logic      clk_core,
  input  logic      rst_core_n,
  input  logic      alu_valid_i,
  input  token_t    alu_token_i,
  input  reg_addr_t alu_rd_i,
  input  logic      alu_wb_i,
  input  word_t     alu_result_i,
  input  word_t     alu_next_pc_i,
  output logic      alu_ready_o,
  input  logic      mem_valid_i,
  input  token_t    mem_token_i,
  input  reg_addr_t mem_rd_i,
  input  logic      mem_wb_i,
  input  word_t     mem_result_i,
  input  word_t     mem_next_pc_i,
  input  logic      mem_trap_i,
  input  cause_t    mem_cause_i,
  input  word_t     mem_tval_i,
  output logic      mem_ready_o,
  input  logic      flush_req_i,
  output logic      flush_ack_o,
  output logic      flush_begin_o,
  output logic      retire_o,
  output logic      wr_en_o,
  output reg_addr_t wr_addr_o,
  output word_t     wr_data_o,
  output reg_mask_t commit_mask_o,
  output logic      trap_o,
  output cause_t    trap_cause_o,
  output word_t     trap_value_o,
  output word_t     next_pc_o
);

  token_t    token;
  logic      alu_take;
  logic      mem_take;
  logic      used_trap;
  logic      used_wb;
  reg_addr_t used_rd;
  word_t     used_result;
  word_t     used_next_pc;
  logic      trap_now;
  logic      advance;
  logic      token_clear;

  // A unit may only retire the op whose token is next
  assign alu_ready_o = token == alu_token_i;
  assign mem_ready_o = token == mem_token_i;

  assign alu_take = alu_ready_o & alu_valid_i;
  assign mem_take = mem_ready_o & mem_valid_i;
  assign retire_o = alu_take | mem_take;

  always_comb begin
    if (alu_take) begin
      used_trap    = 1'b0;
      used_wb      = alu_wb_i;
      used_rd      = alu_rd_i;
      used_result  = alu_result_i;
      used_next_pc = alu_next_pc_i;
    end else begin
      used_trap    = mem_trap_i;
      used_wb      = mem_wb_i;
      used_rd      = mem_rd_i;
      used_result  = mem_result_i;
      used_next_pc = mem_next_pc_i;
    end
  end

  assign trap_now      = retire_o & used_trap;
  assign advance       = retire_o & !used_trap;
  assign flush_begin_o = trap_now;

  assign wr_en_o       = advance & used_wb;
  assign wr_addr_o     = used_rd;
  assign wr_data_o     = used_result;
  assign commit_mask_o = wr_en_o ? (reg_mask_t'(1'b1) << used_rd) : '0;

  // Ack has fallen behind req, so both sides restart from token zero
  assign token_clear = flush_ack_o & !flush_req_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      token       <= '0;
      flush_ack_o <= 1'b1;
      trap_o      <= 1'b0;
      next_pc_o   <= '0;
    end else begin
      flush_ack_o <= flush_req_i;
      trap_o      <= trap_now;
      if (token_clear) begin
        token     <= '0;
        next_pc_o <= TRAP_VECTOR;
      end else if (advance) begin
        token     <= token + 1'b1;
        next_pc_o <= used_next_pc;
      end
    end
  end

  always_ff @(posedge clk_core) begin
    if (trap_now) begin
      trap_cause_o <= mem_cause_i;
      trap_value_o <= mem_tval_i;
    end
  end

endmodule

`default_nettype wire

// File: src/bk_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bk_mem_unit
  import bk_pkg::*;
(
  input  logic             clk_core,
  input  logic             rst_core_n,
  input  logic             valid_i,
  output logic             free_o,
  input  token_t           token_i,
  input  op_t              op_i,
  input  reg_addr_t        rd_i,
  input  word_t            a_i,
  input  word_t            b_i,
  input  word_t            imm_i,
  input  word_t            pc_i,
  input  logic             flush_i,
  output logic             valid_o,
  output token_t           token_o,
  output reg_addr_t        rd_o,
  output logic             wb_o,
  output word_t            result_o,
  output word_t            next_pc_o,
  output logic             trap_o,
  output cause_t           cause_o,
  output word_t            tval_o,
  input  logic             ready_i,
  output logic             wb_cyc_o,
  output logic             wb_stb_o,
  output logic             wb_we_o,
  output word_t            wb_adr_o,
  output word_t            wb_dat_o,
  output logic [SEL_W-1:0] wb_sel_o,
  input  logic             wb_ack_i,
  input  word_t            wb_dat_i
);

  typedef enum logic [1:0] {IDLE, BUS, DONE} mem_state_t;

  mem_state_t state;
  word_t      ea;
  logic       misaligned;
  logic       is_store;
  logic       take;

  assign ea         = a_i + imm_i;
  assign misaligned = ea[1:0] != 2'b00;
  assign is_store   = op_i == OP_STORE;

  assign free_o   = state == IDLE;
  assign valid_o  = state == DONE;
  assign take     = valid_i & free_o & !flush_i;
  assign wb_stb_o = wb_cyc_o;
  assign wb_sel_o = '1;

  // Only this unit traps, so a flush never finds a bus cycle open
  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      state    <= IDLE;
      wb_cyc_o <= 1'b0;
    end else if (flush_i) begin
      state    <= IDLE;
      wb_cyc_o <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (take) begin
            state    <= misaligned ? DONE : BUS;
            wb_cyc_o <= !misaligned;
          end
        end
        BUS: begin
          if (wb_ack_i) begin
            state    <= DONE;
            wb_cyc_o <= 1'b0;
          end
        end
        DONE:    if (ready_i) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_core) begin
    if (take) begin
      token_o   <= token_i;
      rd_o      <= rd_i;
      next_pc_o <= pc_i + 1'b1;
      wb_o      <= !is_store && !misaligned;
      trap_o    <= misaligned;
      cause_o   <= is_store ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED;
      tval_o    <= ea;
      wb_we_o   <= is_store;
      wb_adr_o  <= ea;
      wb_dat_o  <= b_i;
    end
    if (state == BUS && wb_ack_i) result_o <= wb_dat_i;
  end

endmodule

`default_nettype wire

// File: src/bk_alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bk_alu_unit
  import bk_pkg::*;
(
  input  logic      clk_core,
  input  logic      rst_core_n,
  input  logic      valid_i,
  output logic      free_o,
  input  token_t    token_i,
  input  op_t       op_i,
  input  reg_addr_t rd_i,
  input  word_t     a_i,
  input  word_t     b_i,
  input  word_t     imm_i,
  input  word_t     pc_i,
  input  logic      flush_i,
  output logic      valid_o,
  output token_t    token_o,
  output reg_addr_t rd_o,
  output logic      wb_o,
  output word_t     result_o,
  output word_t     next_pc_o,
  input  logic      ready_i
);

  logic  take;
  word_t result_d;

  assign free_o = !valid_o;
  assign take   = valid_i & free_o & !flush_i;

  always_comb begin
    case (op_i)
      OP_SUB:  result_d = a_i - b_i;
      OP_XOR:  result_d = a_i ^ b_i;
      OP_ADDI: result_d = a_i + imm_i;
      default: result_d = a_i + b_i;
    endcase
  end

  // Every ALU op writes its destination
  assign wb_o = 1'b1;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else if (take) begin
      valid_o <= 1'b1;
    end else if (ready_i) begin
      valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_core) begin
    if (take) begin
      token_o   <= token_i;
      rd_o      <= rd_i;
      result_o  <= result_d;
      next_pc_o <= pc_i + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: src/bk_issue.sv
`timescale 1ns/1ps
`default_nettype none

module bk_issue
  import bk_pkg::*;
(
  input  logic      clk_core,
  input  logic      rst_core_n,
  input  logic      insn_valid_i,
  output logic      insn_ready_o,
  input  op_t       insn_op_i,
  input  reg_addr_t insn_rd_i,
  input  reg_addr_t insn_rs1_i,
  input  reg_addr_t insn_rs2_i,
  input  word_t     insn_imm_i,
  input  word_t     insn_pc_i,
  output reg_addr_t rf_addr_a_o,
  output reg_addr_t rf_addr_b_o,
  input  word_t     rf_data_a_i,
  input  word_t     rf_data_b_i,
  output logic      alu_valid_o,
  output logic      mem_valid_o,
  output token_t    iss_token_o,
  output op_t       iss_op_o,
  output reg_addr_t iss_rd_o,
  output word_t     iss_a_o,
  output word_t     iss_b_o,
  output word_t     iss_imm_o,
  output word_t     iss_pc_o,
  input  logic      alu_free_i,
  input  logic      mem_free_i,
  input  reg_mask_t commit_mask_i,
  input  logic      retire_i,
  input  logic      flush_begin_i,
  output logic      flush_req_o,
  input  logic      flush_ack_i
);

  typedef enum logic {RUN, DRAIN} issue_state_t;

  issue_state_t          state;
  reg_mask_t             busy;
  reg_mask_t             set_mask;
  token_t                token;
  logic [INFLIGHT_W-1:0] inflight;
  logic                  disp_valid;
  logic                  disp_mem;
  logic                  is_mem;
  logic                  uses_rs2;
  logic                  writes_rd;
  logic                  hazard;
  logic                  unit_ok;
  logic                  disp_done;
  logic                  accept;
  logic                  token_clear;

  assign is_mem    = insn_op_i inside {OP_LOAD, OP_STORE};
  assign uses_rs2  = insn_op_i inside {OP_ADD, OP_SUB, OP_XOR, OP_STORE};
  assign writes_rd = insn_op_i != OP_STORE;

  assign hazard = busy[insn_rs1_i] | (uses_rs2 & busy[insn_rs2_i]) |
                  (writes_rd & busy[insn_rd_i]);

  assign alu_valid_o = disp_valid & !disp_mem;
  assign mem_valid_o = disp_valid & disp_mem;
  assign disp_done   = (alu_valid_o & alu_free_i) | (mem_valid_o & mem_free_i);

  // Unit must be free and not already targeted by the pending dispatch
  assign unit_ok = is_mem ? (mem_free_i & !mem_valid_o) : (alu_free_i & !alu_valid_o);

  // Blocked while the ack is high so the token clear lands before new ops
  assign insn_ready_o = (state == RUN) & !flush_ack_i & !flush_begin_i & !hazard &
                        unit_ok & (!disp_valid | disp_done) & (inflight < MAX_INFLIGHT);
  assign accept = insn_valid_i & insn_ready_o;

  assign set_mask    = (accept && writes_rd) ? (reg_mask_t'(1'b1) << insn_rd_i) : '0;
  assign token_clear = flush_ack_i & !flush_req_o;
  assign flush_req_o = state == DRAIN;

  assign rf_addr_a_o = insn_rs1_i;
  assign rf_addr_b_o = insn_rs2_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      state      <= RUN;
      busy       <= '0;
      token      <= '0;
      inflight   <= '0;
      disp_valid <= 1'b0;
      disp_mem   <= 1'b0;
    end else begin
      case (state)
        RUN:     if (flush_begin_i) state <= DRAIN;
        DRAIN:   if (alu_free_i && mem_free_i && !disp_valid) state <= RUN;
        default: state <= RUN;
      endcase

      if (flush_begin_i) busy <= '0;
      else busy <= (busy & ~commit_mask_i) | set_mask;

      if (token_clear) begin
        token    <= '0;
        inflight <= '0;
      end else begin
        if (accept) token <= token + 1'b1;
        if (accept && !retire_i) inflight <= inflight + 1'b1;
        else if (!accept && retire_i) inflight <= inflight - 1'b1;
      end

      if (flush_begin_i) begin
        disp_valid <= 1'b0;
      end else if (accept) begin
        disp_valid <= 1'b1;
        disp_mem   <= is_mem;
      end else if (disp_done) begin
        disp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_core) begin
    if (accept) begin
      iss_token_o <= token;
      iss_op_o    <= insn_op_i;
      iss_rd_o    <= insn_rd_i;
      iss_a_o     <= rf_data_a_i;
      iss_b_o     <= rf_data_b_i;
      iss_imm_o   <= insn_imm_i;
      iss_pc_o    <= insn_pc_i;
    end
  end

endmodule

`default_nettype wire

// File: src/bk_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module bk_regfile
  import bk_pkg::*;
(
  input  logic      clk_core,
  input  logic      rst_core_n,
  input  reg_addr_t rd_addr_a_i,
  input  reg_addr_t rd_addr_b_i,
  output word_t     rd_data_a_o,
  output word_t     rd_data_b_o,
  input  logic      wr_en_i,
  input  reg_addr_t wr_addr_i,
  input  word_t     wr_data_i
);

  word_t regs [REG_N];

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      for (int i = 0; i < REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_addr_i != '0)) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // r0 is never written, so it always reads zero
  assign rd_data_a_o = regs[rd_addr_a_i];
  assign rd_data_b_o = regs[rd_addr_b_i];

endmodule

`default_nettype wire

// File: src/bk_pkg.sv
`default_nettype none

package bk_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_N      = 16;
  localparam int REG_AW     = 4;
  localparam int TOKEN_W    = 4;
  localparam int CAUSE_W    = 5;
  localparam int INFLIGHT_W = 4;
  localparam int SEL_W      = WORD_W / 8;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [REG_AW-1:0]  reg_addr_t;
  typedef logic [REG_N-1:0]   reg_mask_t;
  typedef logic [TOKEN_W-1:0] token_t;
  typedef logic [CAUSE_W-1:0] cause_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_ADDI,
    OP_LOAD,
    OP_STORE
  } op_t;

  // Trap causes, RISC-V numbering
  localparam cause_t CAUSE_LOAD_MISALIGNED  = 5'd4;
  localparam cause_t CAUSE_STORE_MISALIGNED = 5'd6;

  localparam word_t TRAP_VECTOR = 32'h0000_0100;

  // Keeps the 4-bit token from wrapping onto a live entry
  localparam int MAX_INFLIGHT = 8;

endpackage

`default_nettype wire
